// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_csr_top -o sim_csr

output=$(./obj_dir/sim_csr)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// ==== src/csr_file.sv ====
module csr_file
    import csr_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  csr_req_t        i_req,
    input  irq_lines_t      i_irq_lines,
    input  logic            i_instr_retired,
    input  trap_state_t     i_state,
    input  logic            i_trap_taken,
    output csr_rsp_t        o_rsp,
    output csr_wr_t         o_wr,
    output irq_lines_t      o_mie,
    output logic [XLEN-1:0] o_mtvec
);

    irq_lines_t       mie_q;
    logic [XLEN-1:0]  mtvec_q;
    logic [XLEN-1:0]  mscratch_q;
    logic [CNT_W-1:0] mcycle_q;
    logic [CNT_W-1:0] minstret_q;

    logic [XLEN-1:0]  mstatus_w;
    logic [XLEN-1:0]  mie_w;
    logic [XLEN-1:0]  mip_w;
    logic [XLEN-1:0]  rdata;
    logic             exists;
    logic             is_write;
    logic             read_only;
    logic             priv_ok;
    logic             illegal;
    logic [XLEN-1:0]  wval;
    logic             wr_en;

    // --------------------
    // Register views
    // --------------------
    always_comb begin
        mstatus_w = '0;
        mstatus_w[MSTATUS_MIE_BIT]       = i_state.mie;
        mstatus_w[MSTATUS_MPIE_BIT]      = i_state.mpie;
        mstatus_w[MSTATUS_MPP_LSB +: 2]  = i_state.mpp;

        mie_w = '0;
        mie_w[MIP_MEI_BIT] = mie_q.ext;
        mie_w[MIP_MSI_BIT] = mie_q.sw;
        mie_w[MIP_MTI_BIT] = mie_q.timer;

        // Pending bits follow the level inputs directly
        mip_w = '0;
        mip_w[MIP_MEI_BIT] = i_irq_lines.ext;
        mip_w[MIP_MSI_BIT] = i_irq_lines.sw;
        mip_w[MIP_MTI_BIT] = i_irq_lines.timer;
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata  = '0;
        exists = 1'b1;
        case (i_req.addr)
            CSR_MSTATUS:  rdata = mstatus_w;
            CSR_MISA:     rdata = MISA_VALUE;
            CSR_MIE:      rdata = mie_w;
            CSR_MTVEC:    rdata = mtvec_q;
            CSR_MSCRATCH: rdata = mscratch_q;
            CSR_MEPC:     rdata = i_state.mepc;
            CSR_MCAUSE:   rdata = i_state.mcause;
            CSR_MTVAL:    rdata = i_state.mtval;
            CSR_MIP:      rdata = mip_w;
            // User shadows see the same counters
            CSR_MCYCLE, CSR_CYCLE:       rdata = mcycle_q[XLEN-1:0];
            CSR_MCYCLEH, CSR_CYCLEH:     rdata = mcycle_q[CNT_W-1:XLEN];
            CSR_MINSTRET, CSR_INSTRET:   rdata = minstret_q[XLEN-1:0];
            CSR_MINSTRETH, CSR_INSTRETH: rdata = minstret_q[CNT_W-1:XLEN];
            default:      exists = 1'b0;
        endcase
    end

    // --------------------
    // Access check
    // --------------------
    // RS and RC with zero data only read
    assign is_write  = (i_req.op == CSR_RW) || (i_req.wdata != '0);
    assign read_only = (i_req.addr[11:10] == 2'b11);
    assign priv_ok   = (2'(i_state.priv) >= i_req.addr[9:8]);
    assign illegal   = i_req.valid & (~exists | ~priv_ok | (read_only & is_write));

    assign o_rsp.rdata   = rdata;
    assign o_rsp.illegal = illegal;

    // New value for the addressed register
    always_comb begin
        case (i_req.op)
            CSR_RS:  wval = rdata | i_req.wdata;
            CSR_RC:  wval = rdata & ~i_req.wdata;
            default: wval = i_req.wdata;
        endcase
    end

    // Trap in the same cycle drops the write
    assign wr_en = i_req.valid & is_write & ~illegal & ~i_trap_taken;

    assign o_wr.valid = wr_en;
    assign o_wr.addr  = i_req.addr;
    assign o_wr.data  = wval;

    // --------------------
    // Local registers
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            // Free-running counts, a write below overrides them
            mcycle_q <= mcycle_q + 1'b1;
            if (i_instr_retired) begin
                minstret_q <= minstret_q + 1'b1;
            end
            if (wr_en) begin
                case (i_req.addr)
                    CSR_MIE: begin
                        mie_q.ext   <= wval[MIP_MEI_BIT];
                        mie_q.sw    <= wval[MIP_MSI_BIT];
                        mie_q.timer <= wval[MIP_MTI_BIT];
                    end
                    // Modes 2 and 3 are reserved, fall back to direct
                    CSR_MTVEC:     mtvec_q <= {wval[XLEN-1:2], wval[1] ? 2'b00 : wval[1:0]};
                    CSR_MSCRATCH:  mscratch_q <= wval;
                    CSR_MCYCLE:    mcycle_q <= {mcycle_q[CNT_W-1:XLEN], wval};
                    CSR_MCYCLEH:   mcycle_q <= {wval, mcycle_q[XLEN-1:0]};
                    CSR_MINSTRET:  minstret_q <= {minstret_q[CNT_W-1:XLEN], wval};
                    CSR_MINSTRETH: minstret_q <= {wval, minstret_q[XLEN-1:0]};
                    default: ;
                endcase
            end
        end
    end

    assign o_mie   = mie_q;
    assign o_mtvec = mtvec_q;

endmodule

// ==== src/csr_irq_arbiter.sv ====
module csr_irq_arbiter
    import csr_pkg::*;
(
    input  irq_lines_t i_pending,
    input  irq_lines_t i_enable,
    input  logic       i_global_en,
    output irq_req_t   o_irq
);

    irq_lines_t live;

    // Pending lines that may actually fire
    always_comb begin
        live.ext   = i_pending.ext & i_enable.ext & i_global_en;
        live.sw    = i_pending.sw & i_enable.sw & i_global_en;
        live.timer = i_pending.timer & i_enable.timer & i_global_en;
    end

    // Fixed priority, external > software > timer
    always_comb begin
        o_irq.valid = live.ext | live.sw | live.timer;
        if (live.ext) begin
            o_irq.cause = INT_M_EXT;
        end else if (live.sw) begin
            o_irq.cause = INT_M_SW;
        end else if (live.timer) begin
            o_irq.cause = INT_M_TIMER;
        end else begin
            o_irq.cause = '0;
        end
    end

endmodule

// ==== src/csr_pkg.sv ====
package csr_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN       = 32;
    localparam int CNT_W      = 64;
    localparam int CSR_ADDR_W = 12;

    // --------------------
    // CSR addresses
    // --------------------
    // Machine trap setup
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    // Machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;
    // User read-only shadows
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE     = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET   = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH  = 12'hC82;

    // MXL=1 plus A, C, I, M and U extension bits
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_1105;

    // Interrupt causes, bit 31 marks an interrupt
    localparam logic [XLEN-1:0] INT_M_SW    = 32'h8000_0003;
    localparam logic [XLEN-1:0] INT_M_TIMER = 32'h8000_0007;
    localparam logic [XLEN-1:0] INT_M_EXT   = 32'h8000_000B;

    // Field positions in mstatus and mip/mie
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MIP_MSI_BIT      = 3;
    localparam int MIP_MTI_BIT      = 7;
    localparam int MIP_MEI_BIT      = 11;

    // mepc is halfword aligned
    localparam logic [XLEN-1:0] MEPC_ALIGN_MASK = 32'hFFFF_FFFE;

    // --------------------
    // Types
    // --------------------
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_lvl_e;

    // Same encoding as funct3[1:0] of the Zicsr instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic                  valid;
        csr_op_e               op;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tval;
    } exc_req_t;

    typedef struct packed {
        logic ext;
        logic sw;
        logic timer;
    } irq_lines_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
    } irq_req_t;

    typedef struct packed {
        logic                  valid;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        priv_lvl_e       priv;
        logic            mie;
        logic            mpie;
        priv_lvl_e       mpp;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } trap_state_t;

    typedef struct packed {
        logic            trap_taken;
        logic            mret_taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== src/csr_top.sv ====
module csr_top
    import csr_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  csr_req_t   i_csr_req,
    input  exc_req_t   i_exc,
    input  logic       i_is_mret,
    input  irq_lines_t i_irq,
    input  logic       i_instr_retired,
    output csr_rsp_t   o_csr_rsp,
    output redirect_t  o_redirect,
    output priv_lvl_e  o_priv
);

    irq_lines_t      mie_en;
    logic [XLEN-1:0] mtvec;
    csr_wr_t         csr_wr;
    trap_state_t     state;
    logic            global_en;
    irq_req_t        irq_req;
    redirect_t       redirect;

    // Register file and access path
    csr_file u_csr_file (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req           (i_csr_req),
        .i_irq_lines     (i_irq),
        .i_instr_retired (i_instr_retired),
        .i_state         (state),
        .i_trap_taken    (redirect.trap_taken),
        .o_rsp           (o_csr_rsp),
        .o_wr            (csr_wr),
        .o_mie           (mie_en),
        .o_mtvec         (mtvec)
    );

    // Interrupt selection
    csr_irq_arbiter u_csr_irq_arbiter (
        .i_pending   (i_irq),
        .i_enable    (mie_en),
        .i_global_en (global_en),
        .o_irq       (irq_req)
    );

    // Privilege, trap entry and MRET
    csr_trap_ctrl u_csr_trap_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_exc           (i_exc),
        .i_irq           (irq_req),
        .i_is_mret       (i_is_mret),
        .i_mtvec         (mtvec),
        .i_wr            (csr_wr),
        .o_state         (state),
        .o_global_irq_en (global_en),
        .o_redirect      (redirect)
    );

    assign o_redirect = redirect;
    assign o_priv     = state.priv;

endmodule

// ==== src/csr_trap_ctrl.sv ====
module csr_trap_ctrl
    import csr_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  exc_req_t        i_exc,
    input  irq_req_t        i_irq,
    input  logic            i_is_mret,
    input  logic [XLEN-1:0] i_mtvec,
    input  csr_wr_t         i_wr,
    output trap_state_t     o_state,
    output logic            o_global_irq_en,
    output redirect_t       o_redirect
);

    priv_lvl_e       priv;
    logic            mst_mie;
    logic            mst_mpie;
    priv_lvl_e       mst_mpp;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;

    logic            trap;
    logic            mret;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_base;
    logic [XLEN-1:0] trap_target;

    // --------------------
    // Trap and MRET decisions
    // --------------------
    // Exception beats interrupt, any trap beats MRET
    assign trap       = i_exc.valid | i_irq.valid;
    assign mret       = i_is_mret & ~trap;
    assign trap_cause = i_exc.valid ? i_exc.cause : i_irq.cause;

    // Direct mode jumps to base, vectored adds 4*code for interrupts only
    assign trap_base = {i_mtvec[XLEN-1:2], 2'b00};
    always_comb begin
        if (i_mtvec[1:0] == 2'b01 && !i_exc.valid) begin
            trap_target = trap_base + {i_irq.cause[XLEN-3:0], 2'b00};
        end else begin
            trap_target = trap_base;
        end
    end

    assign o_redirect.trap_taken = trap;
    assign o_redirect.mret_taken = mret;
    assign o_redirect.target     = trap ? trap_target : mepc;

    // Lower privilege always takes interrupts
    assign o_global_irq_en = mst_mie | (priv != PRIV_M);

    // --------------------
    // State update
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            priv     <= PRIV_M;
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
            mst_mpp  <= PRIV_M;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (trap) begin
            // Interrupts take mepc from the interrupted instruction
            mepc     <= i_exc.pc & MEPC_ALIGN_MASK;
            mcause   <= trap_cause;
            mtval    <= i_exc.valid ? i_exc.tval : '0;
            mst_mpie <= mst_mie;
            mst_mie  <= 1'b0;
            mst_mpp  <= priv;
            priv     <= PRIV_M;
        end else if (mret) begin
            mst_mie  <= mst_mpie;
            mst_mpie <= 1'b1;
            priv     <= mst_mpp;
            mst_mpp  <= PRIV_U;
        end else if (i_wr.valid) begin
            case (i_wr.addr)
                CSR_MSTATUS: begin
                    mst_mie  <= i_wr.data[MSTATUS_MIE_BIT];
                    mst_mpie <= i_wr.data[MSTATUS_MPIE_BIT];
                    // Only U and M exist, other MPP values keep the old one
                    if (i_wr.data[MSTATUS_MPP_LSB +: 2] == 2'b00 ||
                        i_wr.data[MSTATUS_MPP_LSB +: 2] == 2'b11) begin
                        mst_mpp <= priv_lvl_e'(i_wr.data[MSTATUS_MPP_LSB +: 2]);
                    end
                end
                CSR_MEPC:   mepc   <= i_wr.data & MEPC_ALIGN_MASK;
                CSR_MCAUSE: mcause <= i_wr.data;
                CSR_MTVAL:  mtval  <= i_wr.data;
                default: ;
            endcase
        end
    end

    assign o_state.priv   = priv;
    assign o_state.mie    = mst_mie;
    assign o_state.mpie   = mst_mpie;
    assign o_state.mpp    = mst_mpp;
    assign o_state.mepc   = mepc;
    assign o_state.mcause = mcause;
    assign o_state.mtval  = mtval;

endmodule

// ==== verif/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// --------------------
// Mirrored state
// --------------------
priv_lvl_e   ref_priv;
logic        ref_mie;
logic        ref_mpie;
priv_lvl_e   ref_mpp;
logic [31:0] ref_mepc;
logic [31:0] ref_mcause;
logic [31:0] ref_mtval;
irq_lines_t  ref_mie_en;
logic [31:0] ref_mtvec;
logic [31:0] ref_mscratch;
logic [63:0] ref_mcycle;
logic [63:0] ref_minstret;

// Everything cleared, hart starts in M
task automatic reset_model();
    ref_priv     = PRIV_M;
    ref_mie      = 1'b0;
    ref_mpie     = 1'b0;
    ref_mpp      = PRIV_M;
    ref_mepc     = '0;
    ref_mcause   = '0;
    ref_mtval    = '0;
    ref_mie_en   = '0;
    ref_mtvec    = '0;
    ref_mscratch = '0;
    ref_mcycle   = '0;
    ref_minstret = '0;
endtask

function automatic logic csr_exists(logic [11:0] addr);
    case (addr)
        CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
        CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET,
        CSR_MINSTRETH, CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Architectural read value, mip follows the live lines
function automatic logic [31:0] csr_value(logic [11:0] addr, irq_lines_t lines);
    logic [31:0] v;
    v = '0;
    case (addr)
        CSR_MSTATUS: begin
            v[3]     = ref_mie;
            v[7]     = ref_mpie;
            v[12:11] = ref_mpp;
        end
        // MXL=1, then U, M, I, C and A letters
        CSR_MISA: v = (32'h1 << 30) | (32'h1 << 20) | (32'h1 << 12) | (32'h1 << 8)
                      | (32'h1 << 2) | 32'h1;
        CSR_MIE: begin
            v[11] = ref_mie_en.ext;
            v[3]  = ref_mie_en.sw;
            v[7]  = ref_mie_en.timer;
        end
        CSR_MIP: begin
            v[11] = lines.ext;
            v[3]  = lines.sw;
            v[7]  = lines.timer;
        end
        CSR_MTVEC:    v = ref_mtvec;
        CSR_MSCRATCH: v = ref_mscratch;
        CSR_MEPC:     v = ref_mepc;
        CSR_MCAUSE:   v = ref_mcause;
        CSR_MTVAL:    v = ref_mtval;
        CSR_MCYCLE, CSR_CYCLE:       v = ref_mcycle[31:0];
        CSR_MCYCLEH, CSR_CYCLEH:     v = ref_mcycle[63:32];
        CSR_MINSTRET, CSR_INSTRET:   v = ref_minstret[31:0];
        CSR_MINSTRETH, CSR_INSTRETH: v = ref_minstret[63:32];
        default: v = '0;
    endcase
    return v;
endfunction

function automatic logic access_illegal(csr_req_t req);
    logic writes;
    // Set or clear with zero data is only a read
    writes = (req.op == CSR_RW) || (req.wdata != 32'h0);
    return req.valid && (!csr_exists(req.addr) || (2'(ref_priv) < req.addr[9:8])
                         || ((req.addr[11:10] == 2'b11) && writes));
endfunction

function automatic irq_req_t pick_irq(irq_lines_t lines);
    irq_req_t q;
    logic     en;
    en = ref_mie || (ref_priv == PRIV_U);
    q  = '0;
    if (en && lines.ext && ref_mie_en.ext) begin
        q.valid = 1'b1;
        q.cause = 32'h8000_000B;
    end else if (en && lines.sw && ref_mie_en.sw) begin
        q.valid = 1'b1;
        q.cause = 32'h8000_0003;
    end else if (en && lines.timer && ref_mie_en.timer) begin
        q.valid = 1'b1;
        q.cause = 32'h8000_0007;
    end
    return q;
endfunction

function automatic redirect_t expect_redirect(exc_req_t exc, logic mret, irq_lines_t lines);
    redirect_t   r;
    irq_req_t    q;
    logic [31:0] base;
    q            = pick_irq(lines);
    base         = {ref_mtvec[31:2], 2'b00};
    r.trap_taken = exc.valid || q.valid;
    r.mret_taken = mret && !r.trap_taken;
    r.target     = ref_mepc;
    if (exc.valid) begin
        r.target = base;
    end else if (q.valid && ref_mtvec[1:0] == 2'b01) begin
        r.target = base + (q.cause & 32'h7FFF_FFFF) * 4;
    end else if (q.valid) begin
        r.target = base;
    end
    return r;
endfunction

// One rising edge of the reference state
task automatic advance_model(csr_req_t req, exc_req_t exc, logic mret, irq_lines_t lines,
                             logic retired);
    redirect_t   r;
    irq_req_t    q;
    logic [31:0] oldv;
    logic [31:0] newv;
    logic [63:0] cyc;
    logic [63:0] ins;
    logic        wr;
    r    = expect_redirect(exc, mret, lines);
    q    = pick_irq(lines);
    oldv = csr_value(req.addr, lines);
    case (req.op)
        CSR_RS:  newv = oldv | req.wdata;
        CSR_RC:  newv = oldv & ~req.wdata;
        default: newv = req.wdata;
    endcase
    wr  = req.valid && ((req.op == CSR_RW) || (req.wdata != 32'h0))
          && !access_illegal(req) && !r.trap_taken;
    cyc = ref_mcycle;
    ins = ref_minstret;
    ref_mcycle = ref_mcycle + 64'd1;
    if (retired) begin
        ref_minstret = ref_minstret + 64'd1;
    end
    if (r.trap_taken) begin
        ref_mepc   = exc.pc & ~32'h1;
        ref_mcause = exc.valid ? exc.cause : q.cause;
        ref_mtval  = exc.valid ? exc.tval : 32'h0;
        ref_mpie   = ref_mie;
        ref_mie    = 1'b0;
        ref_mpp    = ref_priv;
        ref_priv   = PRIV_M;
    end else if (r.mret_taken) begin
        ref_mie  = ref_mpie;
        ref_mpie = 1'b1;
        ref_priv = ref_mpp;
        ref_mpp  = PRIV_U;
    end
    if (wr) begin
        case (req.addr)
            CSR_MSTATUS: begin
                ref_mie  = newv[3];
                ref_mpie = newv[7];
                // Only U and M are real privilege levels
                if (newv[12:11] == 2'b00 || newv[12:11] == 2'b11) begin
                    ref_mpp = priv_lvl_e'(newv[12:11]);
                end
            end
            CSR_MIE: begin
                ref_mie_en.ext   = newv[11];
                ref_mie_en.sw    = newv[3];
                ref_mie_en.timer = newv[7];
            end
            CSR_MTVEC:     ref_mtvec = newv[1] ? {newv[31:2], 2'b00} : newv;
            CSR_MSCRATCH:  ref_mscratch = newv;
            CSR_MEPC:      ref_mepc = newv & ~32'h1;
            CSR_MCAUSE:    ref_mcause = newv;
            CSR_MTVAL:     ref_mtval = newv;
            CSR_MCYCLE:    ref_mcycle = {cyc[63:32], newv};
            CSR_MCYCLEH:   ref_mcycle = {newv, cyc[31:0]};
            CSR_MINSTRET:  ref_minstret = {ins[63:32], newv};
            CSR_MINSTRETH: ref_minstret = {newv, ins[31:0]};
            default: ;
        endcase
    end
endtask

`endif

// ==== verif/tb_csr_top.sv ====
module tb_csr_top
    import csr_pkg::*;
();

    localparam int N_RAND = 300;
    localparam int N_ILL  = 100;
    localparam int N_IRQ  = 200;
    localparam int N_CNT  = 300;
    // Cycles of all sequences plus directed steps and reset, with 50% margin
    localparam int TEST_CYCLES = 2 * N_RAND + 2 * N_ILL + 5 * N_IRQ + N_CNT + 60;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    logic       i_clk;
    logic       i_rst_n;
    csr_req_t   csr_req;
    exc_req_t   exc;
    logic       is_mret;
    irq_lines_t irq;
    logic       retired;
    csr_rsp_t   csr_rsp;
    redirect_t  redirect;
    priv_lvl_e  priv;

    integer      seed = 32'hc152_1c73;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          i;
    int          k;
    csr_op_e     op;
    logic [11:0] addr;
    exc_req_t    ev;
    irq_lines_t  lines;
    logic [11:0] rw_addrs [5] = '{CSR_MSCRATCH, CSR_MIE, CSR_MTVEC, CSR_MSTATUS, CSR_MEPC};
    logic [11:0] cnt_addrs [8] = '{CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH,
                                   CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH};

    `include "csr_model.svh"

    csr_top u_csr_top (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_csr_req       (csr_req),
        .i_exc           (exc),
        .i_is_mret       (is_mret),
        .i_irq           (irq),
        .i_instr_retired (retired),
        .o_csr_rsp       (csr_rsp),
        .o_redirect      (redirect),
        .o_priv          (priv)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    // Hard stop if a sequence never returns
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // --------------------
    // Per-cycle compare
    // --------------------
    // Outputs settle mid low phase and the model moves on the rising edge
    task automatic sample_and_step(string name);
        redirect_t exp_r;
        #10;
        exp_r = expect_redirect(exc, is_mret, irq);
        if (csr_req.valid) begin
            check_value({name, " rdata"}, csr_value(csr_req.addr, irq), csr_rsp.rdata);
            check_value({name, " illegal"}, 32'(access_illegal(csr_req)),
                        32'(csr_rsp.illegal));
        end
        check_value({name, " trap_taken"}, 32'(exp_r.trap_taken), 32'(redirect.trap_taken));
        check_value({name, " mret_taken"}, 32'(exp_r.mret_taken), 32'(redirect.mret_taken));
        if (exp_r.trap_taken || exp_r.mret_taken) begin
            check_value({name, " target"}, exp_r.target, redirect.target);
        end
        check_value({name, " priv"}, 32'(ref_priv), 32'(priv));
        @(posedge i_clk);
        advance_model(csr_req, exc, is_mret, irq, retired);
    endtask

    task automatic apply(csr_req_t r, exc_req_t e, logic m, irq_lines_t l, string name);
        @(negedge i_clk);
        csr_req = r;
        exc     = e;
        is_mret = m;
        irq     = l;
        retired = 1'($random(seed));
        sample_and_step(name);
    endtask

    function automatic csr_req_t make_req(csr_op_e o, logic [11:0] a, logic [31:0] d);
        csr_req_t r;
        r.valid = 1'b1;
        r.op    = o;
        r.addr  = a;
        r.wdata = d;
        return r;
    endfunction

    task automatic access(csr_op_e o, logic [11:0] a, logic [31:0] d, string name);
        apply(make_req(o, a, d), '0, 1'b0, '0, name);
    endtask

    task automatic read_csr(logic [11:0] a, string name);
        access(CSR_RS, a, 32'h0, name);
    endtask

    initial begin
        i_rst_n = 1'b0;
        csr_req = '0;
        exc     = '0;
        is_mret = 1'b0;
        irq     = '0;
        retired = 1'b0;
        reset_model();
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        sample_and_step("reset_release");

        // Random accesses with read back in the next cycle
        for (i = 0; i < N_RAND; i++) begin
            addr = rw_addrs[{$random(seed)} % 5];
            op   = csr_op_e'(2'(32'd1 + ({$random(seed)} % 3)));
            access(op, addr, $random(seed), "rand_rw");
            read_csr(addr, "rand_readback");
        end

        // Read-only and unknown addresses
        access(CSR_RW, CSR_CYCLE, 32'h1, "ro_write");
        access(CSR_RC, CSR_INSTRET, 32'h8000_0000, "ro_clear");
        access(CSR_RS, CSR_INSTRETH, 32'h0, "ro_read_rs");
        access(CSR_RC, CSR_CYCLEH, 32'h0, "ro_read_rc");
        for (i = 0; i < N_ILL; i++) begin
            access(CSR_RW, 12'($random(seed)), $random(seed), "rand_addr");
            read_csr(rw_addrs[i % 5], "no_change");
        end

        // Exception with a CSR write in the same cycle
        // MPP starts at U so the saved M shows up
        access(CSR_RW, CSR_MTVEC, 32'h0000_4001, "exc_mtvec");
        access(CSR_RW, CSR_MSTATUS, 32'h0000_0008, "exc_mstatus");
        ev       = '0;
        ev.valid = 1'b1;
        ev.cause = 32'($random(seed)) & 32'h0000_000F;
        ev.pc    = $random(seed);
        ev.tval  = $random(seed);
        apply(make_req(CSR_RW, CSR_MSCRATCH, $random(seed)), ev, 1'b0, '0, "exc_entry");
        read_csr(CSR_MEPC, "exc_mepc");
        read_csr(CSR_MCAUSE, "exc_mcause");
        read_csr(CSR_MTVAL, "exc_mtval");
        read_csr(CSR_MSTATUS, "exc_mstatus_after");
        read_csr(CSR_MSCRATCH, "exc_write_dropped");

        // Random interrupts, enables and vector mode
        for (i = 0; i < N_IRQ; i++) begin
            access(CSR_RW, CSR_MIE, $random(seed), "irq_mie");
            access(CSR_RW, CSR_MSTATUS, 32'h0000_1800 | (32'($random(seed)) & 32'h88),
                   "irq_mstatus");
            access(CSR_RW, CSR_MTVEC, $random(seed), "irq_mtvec");
            ev    = '0;
            ev.pc = $random(seed);
            lines = irq_lines_t'(3'($random(seed)));
            apply(make_req(CSR_RS, CSR_MIP, 32'h0), ev, 1'b0, lines, "irq_take");
            read_csr(CSR_MCAUSE, "irq_cause");
        end

        // MRET into U, trap from U, then back to U
        access(CSR_RW, CSR_MIE, 32'h0000_0888, "mret_mie");
        access(CSR_RW, CSR_MEPC, $random(seed), "mret_mepc");
        // MPP of M stays in M and every mstatus field moves
        access(CSR_RW, CSR_MSTATUS, 32'h0000_1808, "mret_m_setup");
        apply('0, '0, 1'b1, '0, "mret_to_m");
        read_csr(CSR_MSTATUS, "mret_m_mstatus");
        access(CSR_RW, CSR_MSTATUS, 32'h0000_0080, "mret_setup");
        apply('0, '0, 1'b1, '0, "mret_to_user");
        read_csr(CSR_MSTATUS, "user_mstatus");
        read_csr(CSR_MSCRATCH, "user_mscratch");
        read_csr(CSR_CYCLE, "user_cycle");
        read_csr(CSR_INSTRETH, "user_instreth");
        access(CSR_RW, CSR_CYCLE, 32'h1, "user_cycle_write");
        ev       = '0;
        ev.valid = 1'b1;
        ev.cause = 32'h0000_0008;
        ev.pc    = $random(seed);
        apply('0, ev, 1'b0, '0, "user_ecall");
        read_csr(CSR_MSTATUS, "ecall_mstatus");
        read_csr(CSR_MEPC, "ecall_mepc");
        // MIE off, but U still takes interrupts
        access(CSR_RW, CSR_MSTATUS, 32'h0000_0000, "mret_setup_off");
        apply('0, '0, 1'b1, '0, "mret_again");
        ev    = '0;
        ev.pc = $random(seed);
        apply('0, ev, 1'b0, 3'b010, "user_irq");
        read_csr(CSR_MCAUSE, "user_irq_cause");
        read_csr(CSR_MSTATUS, "user_irq_mstatus");

        // Counters, writes and shadow reads
        read_csr(CSR_MCYCLE, "mcycle_since_reset");
        read_csr(CSR_MINSTRET, "minstret_count");
        for (i = 0; i < N_CNT; i++) begin
            k = {$random(seed)} % 8;
            if (k < 4 && ({$random(seed)} % 4) == 0) begin
                access(CSR_RW, cnt_addrs[k], $random(seed), "counter_write");
            end else begin
                read_csr(cnt_addrs[k], "counter_read");
            end
        end

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verif
src/csr_pkg.sv
src/csr_irq_arbiter.sv
src/csr_trap_ctrl.sv
src/csr_file.sv
src/csr_top.sv
verif/tb_csr_top.sv
